// ==== Makefile ====
# Verilator simulation of the level meter

TOP := tb_level_meter

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, pass or fail read from sim.log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

obj_dir/V$(TOP): files.f hdl/*.sv sim/*.sv include/*.svh
	verilator --binary --timing --timescale 1ns/1ns -f files.f \
		--top-module $(TOP) -Mdir obj_dir

test: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "^Everything OK$$" sim.log && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir sim.log

// ==== files.f ====
+incdir+include
hdl/level_meter_pkg.sv
hdl/peak_picker.sv
hdl/peak_buffer.sv
hdl/magnitude_to_db.sv
hdl/level_meter_top.sv
sim/tb_level_meter.sv

// ==== hdl/level_meter_pkg.sv ====
`include "level_meter_defines.svh"

package level_meter_pkg;

    //////////////////////////////
    // Data types
    //////////////////////////////

    // Raw two's complement sample from the audio source
    typedef logic signed [`LM_SAMPLE_WIDTH-1:0] sample_t;
    // Unsigned magnitude, reaches 2048 for the most negative sample
    typedef logic [`LM_SAMPLE_WIDTH-1:0] magnitude_t;
    // Whole dB below full scale
    typedef logic [8:0] atten_t;

    //////////////////////////////
    // dB lookup tables
    //////////////////////////////

    // Quarter-dB gain for a leading one at bit position lead_pos
    // Roughly 6 dB (24 quarters) per bit
    function automatic atten_t gain_msb_lookup(input logic [3:0] lead_pos);
        case (lead_pos)
            4'd0:    return 9'd265;
            4'd1:    return 9'd241;
            4'd2:    return 9'd217;
            4'd3:    return 9'd193;
            4'd4:    return 9'd169;
            4'd5:    return 9'd145;
            4'd6:    return 9'd120;
            4'd7:    return 9'd96;
            4'd8:    return 9'd72;
            4'd9:    return 9'd48;
            4'd10:   return 9'd24;
            default: return 9'd0;
        endcase
    endfunction

    // Quarter-dB correction for the four bits under the leading one
    function automatic atten_t gain_fraction_lookup(input logic [3:0] remainder);
        atten_t table_q [16] = '{9'd0, 9'd2, 9'd4, 9'd6, 9'd8, 9'd9, 9'd11, 9'd13,
                                 9'd14, 9'd16, 9'd17, 9'd18, 9'd19, 9'd21, 9'd22, 9'd23};
        return table_q[remainder];
    endfunction

endpackage

// ==== hdl/level_meter_top.sv ====
`timescale 1ns/1ns

module level_meter_top (
    input  logic                     clock,
    input  logic                     reset,
    // Sample stream, no back-pressure
    input  level_meter_pkg::sample_t sample,
    input  logic                     sample_valid,
    // Per-window level in whole dB below full scale
    output level_meter_pkg::atten_t  atten,
    output logic                     atten_valid,
    // A window peak was lost
    output logic                     overflow
);
    import level_meter_pkg::*;

    //////////////////////////////
    // Write bus, picker to buffer
    //////////////////////////////

    logic       wr_cyc;
    logic       wr_stb;
    magnitude_t wr_dat;
    logic       wr_ack;

    //////////////////////////////
    // Read bus, buffer to converter
    //////////////////////////////

    logic       rd_cyc;
    logic       rd_stb;
    magnitude_t rd_dat;
    logic       rd_ack;

    // Window peaks out of the sample stream
    peak_picker peak_picker_i (
        .clock        (clock),
        .reset        (reset),
        .sample       (sample),
        .sample_valid (sample_valid),
        .wr_cyc       (wr_cyc),
        .wr_stb       (wr_stb),
        .wr_dat       (wr_dat),
        .wr_ack       (wr_ack),
        .overflow     (overflow)
    );

    // FIFO between the two bus masters
    peak_buffer peak_buffer_i (
        .clock  (clock),
        .reset  (reset),
        .wr_cyc (wr_cyc),
        .wr_stb (wr_stb),
        .wr_dat (wr_dat),
        .wr_ack (wr_ack),
        .rd_cyc (rd_cyc),
        .rd_stb (rd_stb),
        .rd_dat (rd_dat),
        .rd_ack (rd_ack)
    );

    // Peak magnitude to dB
    magnitude_to_db magnitude_to_db_i (
        .clock       (clock),
        .reset       (reset),
        .rd_cyc      (rd_cyc),
        .rd_stb      (rd_stb),
        .rd_dat      (rd_dat),
        .rd_ack      (rd_ack),
        .atten       (atten),
        .atten_valid (atten_valid)
    );

endmodule

// ==== hdl/magnitude_to_db.sv ====
`timescale 1ns/1ns

module magnitude_to_db (
    input  logic                        clock,
    input  logic                        reset,
    // Wishbone classic read master
    output logic                        rd_cyc,
    output logic                        rd_stb,
    input  level_meter_pkg::magnitude_t rd_dat,
    input  logic                        rd_ack,
    // Attenuation result, one cycle strobe
    output level_meter_pkg::atten_t     atten,
    output logic                        atten_valid
);
    import level_meter_pkg::*;

    // Bit index of the magnitude MSB, 11 for the 12-bit tables
    localparam int MAG_TOP = $bits(magnitude_t) - 1;

    typedef enum logic [2:0] {
        ST_REQUEST,
        ST_WAIT_ACK,
        ST_SHIFT,
        ST_LOOKUP,
        ST_OUTPUT
    } state_t;

    state_t state;

    // Registered cyc/stb of the read bus
    logic read_req;
    // Magnitude shifted left until its leading one is at the top
    magnitude_t norm_mag;
    // Original position of that leading one
    logic [3:0] lead_pos;
    // Up to four bits under the leading one, right aligned
    logic [3:0] remainder;
    // Table outputs in quarter dB
    atten_t msb_gain;
    atten_t frac_gain;

    //////////////////////////////
    // Remainder and table lookup
    //////////////////////////////

    // Low positions have fewer bits under the leading one
    always_comb begin
        case (lead_pos)
            4'd0:    remainder = 4'd0;
            4'd1:    remainder = {3'b000, norm_mag[MAG_TOP-1]};
            4'd2:    remainder = {2'b00, norm_mag[MAG_TOP-1 -: 2]};
            4'd3:    remainder = {1'b0, norm_mag[MAG_TOP-1 -: 3]};
            default: remainder = norm_mag[MAG_TOP-1 -: 4];
        endcase
    end

    assign msb_gain  = gain_msb_lookup(lead_pos);
    assign frac_gain = gain_fraction_lookup(remainder);

    //////////////////////////////
    // Control FSM
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= ST_REQUEST;
            read_req <= 1'b0;
        end else begin
            case (state)
                // First read after reset
                ST_REQUEST: begin
                    read_req <= 1'b1;
                    state    <= ST_WAIT_ACK;
                end
                // Hold the request until the buffer has a peak
                ST_WAIT_ACK: begin
                    if (rd_ack) begin
                        read_req <= 1'b0;
                        // Top bit already set means no shifting
                        state <= rd_dat[MAG_TOP] ? ST_LOOKUP : ST_SHIFT;
                    end
                end
                // One bit per cycle, stop when the next shift tops out
                ST_SHIFT: begin
                    if (norm_mag[MAG_TOP-1] || lead_pos == 4'd1) begin
                        state <= ST_LOOKUP;
                    end
                end
                ST_LOOKUP: begin
                    state <= ST_OUTPUT;
                end
                // Result strobe, next read request goes out right behind it
                ST_OUTPUT: begin
                    read_req <= 1'b1;
                    state    <= ST_WAIT_ACK;
                end
                default: begin
                    read_req <= 1'b0;
                    state    <= ST_REQUEST;
                end
            endcase
        end
    end

    //////////////////////////////
    // Datapath
    //////////////////////////////

    always_ff @(posedge clock) begin
        case (state)
            ST_WAIT_ACK: begin
                if (rd_ack) begin
                    norm_mag <= rd_dat;
                    lead_pos <= 4'(MAG_TOP);
                end
            end
            ST_SHIFT: begin
                norm_mag <= norm_mag << 1;
                lead_pos <= lead_pos - 1'b1;
            end
            // Quarter dB down to whole dB, rounding toward zero
            ST_LOOKUP: begin
                atten <= (msb_gain - frac_gain) >> 2;
            end
            default: begin
                norm_mag <= norm_mag;
            end
        endcase
    end

    assign rd_cyc      = read_req;
    assign rd_stb      = read_req;
    assign atten_valid = (state == ST_OUTPUT);

endmodule

// ==== hdl/peak_buffer.sv ====
`timescale 1ns/1ns
`include "level_meter_defines.svh"

module peak_buffer (
    input  logic                        clock,
    input  logic                        reset,
    // Wishbone classic write slave
    input  logic                        wr_cyc,
    input  logic                        wr_stb,
    input  level_meter_pkg::magnitude_t wr_dat,
    output logic                        wr_ack,
    // Wishbone classic read slave
    input  logic                        rd_cyc,
    input  logic                        rd_stb,
    output level_meter_pkg::magnitude_t rd_dat,
    output logic                        rd_ack
);
    import level_meter_pkg::*;

    localparam int DEPTH   = `LM_BUFFER_DEPTH;
    localparam int PTR_W   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_W = $clog2(DEPTH + 1);

    // Peak storage
    magnitude_t mem [DEPTH];

    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    // Number of stored peaks
    logic [COUNT_W-1:0] count;

    logic full;
    logic empty;
    // Transfers accepted this cycle, acked on the next
    logic wr_go;
    logic rd_go;

    //////////////////////////////
    // Handshake decode
    //////////////////////////////

    assign full  = (count == COUNT_W'(DEPTH));
    assign empty = (count == '0);

    // The master keeps stb up during the ack cycle
    // so the ack flag blocks a second transfer
    assign wr_go = wr_cyc && wr_stb && !wr_ack && !full;
    assign rd_go = rd_cyc && rd_stb && !rd_ack && !empty;

    //////////////////////////////
    // Pointers and fill level
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            wr_ack <= 1'b0;
            rd_ack <= 1'b0;
        end else begin
            // One cycle ack pulses
            wr_ack <= wr_go;
            rd_ack <= rd_go;
            if (wr_go) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_go) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous write and read leave the level unchanged
            case ({wr_go, rd_go})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    //////////////////////////////
    // Storage
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (wr_go) begin
            mem[wr_ptr] <= wr_dat;
        end
        // Oldest entry lands on rd_dat together with rd_ack
        if (rd_go) begin
            rd_dat <= mem[rd_ptr];
        end
    end

endmodule

// ==== hdl/peak_picker.sv ====
`timescale 1ns/1ns
`include "level_meter_defines.svh"

module peak_picker (
    input  logic                     clock,
    input  logic                     reset,
    input  level_meter_pkg::sample_t sample,
    input  logic                     sample_valid,
    // Wishbone classic write master
    output logic                          wr_cyc,
    output logic                          wr_stb,
    output level_meter_pkg::magnitude_t   wr_dat,
    input  logic                          wr_ack,
    // Sticky lost-peak flag
    output logic                     overflow
);
    import level_meter_pkg::*;

    localparam int COUNT_W  = $clog2(`LM_WINDOW_LEN);
    localparam int SIGN_BIT = $bits(sample_t) - 1;

    // Position of the current sample inside its window
    logic [COUNT_W-1:0] sample_count;
    // Magnitude of the incoming sample
    magnitude_t sample_mag;
    // Peak of the samples already taken in this window
    magnitude_t window_max;
    // Peak including the incoming sample
    magnitude_t running_max;
    // Last sample of a window arrives this cycle
    logic window_done;
    // A finished peak sits on the bus waiting for ack
    logic wr_pending;
    magnitude_t peak_data;

    //////////////////////////////
    // Magnitude and running peak
    //////////////////////////////

    // Negating -2048 wraps to 12'h800, which reads as 2048 unsigned
    always_comb begin
        if (sample[SIGN_BIT]) begin
            sample_mag = magnitude_t'(-sample);
        end else begin
            sample_mag = magnitude_t'(sample);
        end
    end

    // First sample of a window ignores the stale maximum
    always_comb begin
        if (sample_count == '0 || sample_mag > window_max) begin
            running_max = sample_mag;
        end else begin
            running_max = window_max;
        end
    end

    assign window_done = sample_valid && (sample_count == COUNT_W'(`LM_WINDOW_LEN - 1));

    //////////////////////////////
    // Window control
    //////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            sample_count <= '0;
            wr_pending   <= 1'b0;
            overflow     <= 1'b0;
        end else begin
            if (sample_valid) begin
                sample_count <= window_done ? '0 : sample_count + 1'b1;
            end
            // Bus released in the cycle after ack
            if (wr_ack) begin
                wr_pending <= 1'b0;
            end
            // A peak that finds the bus busy is lost for good
            // An ack in this same cycle still counts as busy
            if (window_done) begin
                if (wr_pending) begin
                    overflow <= 1'b1;
                end else begin
                    wr_pending <= 1'b1;
                end
            end
        end
    end

    // Running maximum and the peak offered to the buffer
    always_ff @(posedge clock) begin
        if (sample_valid) begin
            window_max <= running_max;
        end
        if (window_done && !wr_pending) begin
            peak_data <= running_max;
        end
    end

    // cyc and stb move together, data held until ack
    assign wr_cyc = wr_pending;
    assign wr_stb = wr_pending;
    assign wr_dat = peak_data;

endmodule

// ==== include/level_meter_defines.svh ====
`ifndef LEVEL_METER_DEFINES_SVH
`define LEVEL_METER_DEFINES_SVH

//////////////////////////////
// Level meter build constants
//////////////////////////////

// Width of one input sample in bits
// The dB tables are built for exactly 12 bits
`define LM_SAMPLE_WIDTH 12

// Samples per peak window
// One peak is produced for every window
`define LM_WINDOW_LEN 8

// Entries in the peak FIFO between picker and converter
// Sized to absorb a short burst of windows
`define LM_BUFFER_DEPTH 4

//////////////////////////////
// End of constants
//////////////////////////////

`endif

// ==== sim/tb_level_meter.sv ====
`timescale 1ns/1ns
`include "level_meter_defines.svh"

module tb_level_meter;

    localparam int WIN            = `LM_WINDOW_LEN;
    localparam int SWEEP_WINDOWS  = 2048;
    localparam int RANDOM_WINDOWS = 100;
    localparam int BURSTS         = 5;
    localparam int FLOOD_WINDOWS  = 40;
    // Four basic windows plus three per burst
    localparam int TOTAL_WINDOWS  = 4 + SWEEP_WINDOWS + RANDOM_WINDOWS + 3 * BURSTS
                                    + FLOOD_WINDOWS;
    localparam int CYCLE_LIMIT    = 40 * TOTAL_WINDOWS;

    logic                     clock;
    logic                     reset;
    level_meter_pkg::sample_t sample;
    logic                     sample_valid;
    level_meter_pkg::atten_t  atten;
    logic                     atten_valid;
    logic                     overflow;

    // Quarter-dB tables of the reference model
    int msb_quarter_db [12]  = '{265, 241, 217, 193, 169, 145, 120, 96, 72, 48, 24, 0};
    int frac_quarter_db [16] = '{0, 2, 4, 6, 8, 9, 11, 13, 14, 16, 17, 18, 19, 21, 22, 23};

    // Samples of the window about to be sent
    int window_buf [$];
    int expected_q [$];
    int received_q [$];
    string test_name;
    // Flood test lets dropped windows be skipped
    bit skip_allowed = 1'b0;
    int check_count  = 0;
    int error_count  = 0;
    int test_checks;
    int test_errors;
    int cycle_count  = 0;

    level_meter_top dut_i (
        .clock        (clock),
        .reset        (reset),
        .sample       (sample),
        .sample_valid (sample_valid),
        .atten        (atten),
        .atten_valid  (atten_valid),
        .overflow     (overflow)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    //////////////////////////////
    // Reference model
    //////////////////////////////

    // Whole dB below full scale for one magnitude
    function automatic int expected_atten(input int mag);
        int lead;
        int rem;
        lead = 0;
        for (int b = 0; b < 12; b++) begin
            if ((mag >> b) & 1) begin
                lead = b;
            end
        end
        // Up to four bits right under the leading one
        if (lead >= 4) begin
            rem = (mag >> (lead - 4)) & 15;
        end else begin
            rem = mag & ((1 << lead) - 1);
        end
        return (msb_quarter_db[lead] - frac_quarter_db[rem]) / 4;
    endfunction

    // Largest magnitude of the window, then its dB value
    function automatic int window_expected();
        int peak;
        int mag;
        peak = 0;
        foreach (window_buf[i]) begin
            mag = (window_buf[i] < 0) ? -window_buf[i] : window_buf[i];
            if (mag > peak) begin
                peak = mag;
            end
        end
        return expected_atten(peak);
    endfunction

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    task automatic fail_value(input string label, input int expected, input int actual);
        $display("[FAIL] %s: expected %0d, actual %0d", label, expected, actual);
        error_count++;
    endtask

    task automatic fail_plain(input string what);
        $display("Error in test %s: %s", test_name, what);
        error_count++;
    endtask

    // Each sample's magnitude stays at or below 2 to the power max_bits
    task automatic fill_random(input int max_bits);
        int span;
        window_buf.delete();
        repeat (WIN) begin
            span = 1 << $urandom_range(0, max_bits);
            window_buf.push_back(int'($urandom_range(0, 2 * span - 1)) - span);
        end
    endtask

    // One nonzero sample at pos
    task automatic fill_single(input int value, input int pos);
        window_buf.delete();
        repeat (WIN) window_buf.push_back(0);
        window_buf[pos] = value;
    endtask

    // Valid stays high so windows can run back to back
    task automatic send_window();
        foreach (window_buf[i]) begin
            @(negedge clock);
            sample       = level_meter_pkg::sample_t'(window_buf[i]);
            sample_valid = 1'b1;
        end
        expected_q.push_back(window_expected());
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge clock);
            sample       = '0;
            sample_valid = 1'b0;
        end
    endtask

    // Until every sent window has its result
    task automatic drain_results();
        idle_cycles(1);
        while (expected_q.size() > 0) idle_cycles(1);
    endtask

    // Until the converter has been silent for quiet cycles
    task automatic wait_quiet(input int quiet);
        int still;
        still = 0;
        while (still < quiet) begin
            idle_cycles(1);
            still = atten_valid ? 0 : still + 1;
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_checks = check_count;
        test_errors = error_count;
        received_q.delete();
    endtask

    task automatic end_test();
        $display("Test %s finished: %0d checks, %0d errors", test_name,
                 check_count - test_checks, error_count - test_errors);
    endtask

    //////////////////////////////
    // Result comparison
    //////////////////////////////

    // Outputs are settled at the falling edge
    always @(negedge clock) begin
        int got;
        int want;
        bit matched;
        if (!reset && atten_valid) begin
            got = int'(atten);
            received_q.push_back(got);
            check_count++;
            if (expected_q.size() == 0) begin
                fail_plain($sformatf("result %0d arrived with no window pending", got));
            end else if (skip_allowed) begin
                // Dropped windows are passed over in window order
                matched = 1'b0;
                while (!matched && expected_q.size() > 0) begin
                    want = expected_q.pop_front();
                    matched = (want == got);
                end
                if (!matched) begin
                    fail_plain($sformatf("result %0d matches no later window", got));
                end
            end else begin
                want = expected_q.pop_front();
                if (got != want) begin
                    fail_value(test_name, want, got);
                end
            end
        end
    end

    // Run limit
    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run did not end within %0d cycles", CYCLE_LIMIT);
            $display("Something failed");
            $finish;
        end
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        void'($urandom(47990));
        reset        = 1'b1;
        sample       = '0;
        sample_valid = 1'b0;
        repeat (3) @(negedge clock);
        reset = 1'b0;
        test_name = "reset";
        if (overflow !== 1'b0 || atten_valid !== 1'b0) begin
            fail_plain("outputs not low after reset");
        end

        // Full scale, silence and sign
        begin_test("basic");
        fill_random(10);
        window_buf[3] = -2048;
        send_window();
        drain_results();
        fill_single(0, 0);
        send_window();
        drain_results();
        fill_single(1000, 5);
        send_window();
        drain_results();
        fill_single(-1000, 2);
        send_window();
        drain_results();
        check_count += 3;
        if (received_q.size() != 4) begin
            fail_plain("did not get four results");
        end else begin
            if (received_q[0] != 0) begin
                fail_value("basic full scale", 0, received_q[0]);
            end
            if (received_q[1] != 66) begin
                fail_value("basic zero", 66, received_q[1]);
            end
            if (received_q[2] != received_q[3]) begin
                fail_value("basic sign", received_q[2], received_q[3]);
            end
        end
        end_test();

        // Every magnitude with one window in flight at a time
        begin_test("sweep");
        for (int mag = 0; mag < SWEEP_WINDOWS; mag++) begin
            fill_single((mag % 2) ? -mag : mag, mag % WIN);
            send_window();
            drain_results();
        end
        end_test();

        // Gap between windows is longer than the slowest conversion
        begin_test("random");
        repeat (RANDOM_WINDOWS) begin
            fill_random($urandom_range(0, 11));
            send_window();
            idle_cycles(20);
        end
        drain_results();
        end_test();

        // Small peaks give the longest conversions so peaks queue in the FIFO
        begin_test("burst");
        repeat (BURSTS) begin
            repeat (3) begin
                fill_random(2);
                send_window();
            end
            drain_results();
        end
        check_count++;
        if (overflow !== 1'b0) begin
            fail_plain("overflow went high");
        end
        end_test();

        // Nonstop stream outruns the converter
        begin_test("flood");
        skip_allowed = 1'b1;
        repeat (FLOOD_WINDOWS) begin
            fill_random(3);
            send_window();
        end
        wait_quiet(40);
        check_count += 2;
        if (overflow !== 1'b1) begin
            fail_plain("overflow stayed low");
        end
        if (received_q.size() == 0) begin
            fail_plain("no result arrived");
        end
        // Windows left over here were dropped by the picker
        expected_q.delete();
        skip_allowed = 1'b0;
        end_test();

        $display("All tests done: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule
